/* source/opreq_defs.svh */
// Geometry of one lane's VRF and the number of operand requesters
// NR_BANKS must be a power of two and the top level expects exactly two requesters
`ifndef OPREQ_DEFS_SVH
`define OPREQ_DEFS_SVH

// Number of VRF banks
`define NR_BANKS 4

// Operand requesters, one per priority class
`define NR_OPQUEUES 2

// Data word width
`define ELEN 64

// Architectural vector registers
`define NR_VREGS 32

// 64-bit words per vector register in one lane
`define VREG_WORDS 16

// Width of the vector-length field
`define VL_WIDTH 10

`endif

/* source/vrf_pkg.sv */
// VRF addressing for one lane; the low address bits select the bank
`include "opreq_defs.svh"

package vrf_pkg;

  // Derived geometry
  localparam int unsigned VRF_WORDS = `NR_VREGS * `VREG_WORDS;
  localparam int unsigned ADDR_BITS = $clog2(VRF_WORDS);
  localparam int unsigned BANK_BITS = $clog2(`NR_BANKS);

  // Word address within the lane's VRF
  typedef logic [ADDR_BITS-1:0] vaddr_t;

  // Bank index, taken from the low address bits
  typedef logic [BANK_BITS-1:0] bank_sel_t;

  // Row inside a bank
  typedef logic [ADDR_BITS-BANK_BITS-1:0] vrow_t;

  // Data word and its byte enables
  typedef logic [`ELEN-1:0]   elen_t;
  typedef logic [`ELEN/8-1:0] strb_t;

endpackage

/* source/opreq_pkg.sv */
// Read command and requester types; vl counts elements of width eew
`include "opreq_defs.svh"

package opreq_pkg;

  // Vector register number
  typedef logic [$clog2(`NR_VREGS)-1:0] vreg_t;

  // Element count
  typedef logic [`VL_WIDTH-1:0] vlen_t;

  // Element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Target operand queue of a read
  typedef enum logic {
    OPQ_A = 1'b0,
    OPQ_B = 1'b1
  } opqueue_e;

  // Operand requester state
  typedef enum logic {
    IDLE,
    REQUESTING
  } req_state_e;

endpackage

/* source/vrf_req_if.sv */
// One master's bank request; gnt comes back in the same cycle
// A master raises at most one bank_req bit and holds its payload until granted
`timescale 1ns/100ps
`include "opreq_defs.svh"

interface vrf_req_if;

  import vrf_pkg::*;
  import opreq_pkg::*;

  // One bit per bank
  logic [`NR_BANKS-1:0] bank_req;
  logic                 gnt;

  // Payload
  vrow_t    row;
  logic     wen;
  elen_t    wdata;
  strb_t    be;
  opqueue_e tgt;

  modport master (
    output bank_req,
    output row,
    output wen,
    output wdata,
    output be,
    output tgt,
    input  gnt
  );

  modport arbiter (
    input  bank_req,
    input  row,
    input  wen,
    input  wdata,
    input  be,
    input  tgt,
    output gnt
  );

endinterface

/* source/operand_requester_fsm.sv */
// Reads one vector register from word 0, with no vstart offset
// The element count saturates at zero, so a partial last word is still read
`timescale 1ns/100ps
`include "opreq_defs.svh"

module operand_requester_fsm #(
  parameter opreq_pkg::opqueue_e QUEUE = opreq_pkg::OPQ_A
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Read command
  input  logic             cmd_valid_i,
  output logic             cmd_ready_o,
  input  opreq_pkg::vreg_t cmd_vs_i,
  input  opreq_pkg::vlen_t cmd_vl_i,
  input  opreq_pkg::vew_e  cmd_eew_i,
  // Operand queue
  input  logic             queue_ready_i,
  output logic             issued_o,
  // Bank request
  vrf_req_if.master        vrf
);

  import vrf_pkg::*;
  import opreq_pkg::*;

  req_state_e state_q, state_d;
  vaddr_t     addr_q, addr_d;
  vlen_t      len_q, len_d;
  vew_e       eew_q, eew_d;

  vlen_t      step;
  vlen_t      len_next;
  bank_sel_t  bank;
  logic       active;
  logic       last_word;
  logic       cmd_take;

  //////////////////////////////
  // Word request
  //////////////////////////////

  // Elements per 64-bit word
  assign step     = vlen_t'(8) >> eew_q;
  assign len_next = (len_q > step) ? len_q - step : '0;

  assign active = (state_q == REQUESTING) && queue_ready_i;
  assign bank   = bank_sel_t'(addr_q);

  always_comb begin
    vrf.bank_req       = '0;
    vrf.bank_req[bank] = active;
  end

  assign vrf.row   = vrow_t'(addr_q >> BANK_BITS);
  assign vrf.wen   = 1'b0;
  assign vrf.wdata = '0;
  assign vrf.be    = '0;
  assign vrf.tgt   = QUEUE;

  assign issued_o    = active && vrf.gnt;
  assign last_word   = issued_o && (len_next == '0);

  // Also ready on the last grant, so commands can run back to back
  assign cmd_ready_o = (state_q == IDLE) || last_word;
  assign cmd_take    = cmd_valid_i && cmd_ready_o;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    len_d   = len_q;
    eew_d   = eew_q;

    if (issued_o) begin
      addr_d = addr_q + 1'b1;
      len_d  = len_next;
      if (last_word) begin
        state_d = IDLE;
      end
    end

    // A new command overrides the step of the finished one
    if (cmd_take) begin
      addr_d  = vaddr_t'(cmd_vs_i) << $clog2(`VREG_WORDS);
      len_d   = cmd_vl_i;
      eew_d   = cmd_eew_i;
      // Zero-length commands are acknowledged and dropped
      state_d = (cmd_vl_i != '0) ? REQUESTING : IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      addr_q  <= '0;
      len_q   <= '0;
      eew_q   <= EW8;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      len_q   <= len_d;
      eew_q   <= eew_d;
    end
  end

endmodule

/* source/result_stream_register.sv */
// One-entry buffer for load-unit writes; refills in the cycle it drains
`timescale 1ns/100ps

module result_stream_register (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Write result from the load unit
  input  logic            valid_i,
  output logic            ready_o,
  input  vrf_pkg::vaddr_t addr_i,
  input  vrf_pkg::elen_t  wdata_i,
  input  vrf_pkg::strb_t  be_i,
  // Write request towards the banks
  vrf_req_if.master       vrf
);

  import vrf_pkg::*;
  import opreq_pkg::*;

  logic   full_q;
  logic   load;
  vaddr_t addr_q;
  elen_t  wdata_q;
  strb_t  be_q;

  // Free when empty or when the entry is granted this cycle
  assign ready_o = !full_q || vrf.gnt;
  assign load    = valid_i && ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (vrf.gnt) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

  always_comb begin
    vrf.bank_req                     = '0;
    vrf.bank_req[bank_sel_t'(addr_q)] = full_q;
  end

  assign vrf.row   = vrow_t'(addr_q >> BANK_BITS);
  assign vrf.wen   = 1'b1;
  assign vrf.wdata = wdata_q;
  assign vrf.be    = be_q;
  // Writes carry no queue target
  assign vrf.tgt   = OPQ_A;

endmodule

/* source/vrf_bank_arbiter.sv */
// One grant per bank per cycle; the high class always beats the low class
// Read and write of a class alternate on a bank only when both ask
`timescale 1ns/100ps
`include "opreq_defs.svh"

module vrf_bank_arbiter (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Masters
  vrf_req_if.arbiter                           hp_rd,
  vrf_req_if.arbiter                           hp_wr,
  vrf_req_if.arbiter                           lp_rd,
  vrf_req_if.arbiter                           lp_wr,
  // VRF banks
  output logic                [`NR_BANKS-1:0] vrf_req_o,
  output vrf_pkg::vrow_t      [`NR_BANKS-1:0] vrf_row_o,
  output logic                [`NR_BANKS-1:0] vrf_wen_o,
  output vrf_pkg::elen_t      [`NR_BANKS-1:0] vrf_wdata_o,
  output vrf_pkg::strb_t      [`NR_BANKS-1:0] vrf_be_o,
  output opreq_pkg::opqueue_e [`NR_BANKS-1:0] vrf_tgt_o
);

  import vrf_pkg::*;
  import opreq_pkg::*;

  // Master slots, the read of each class on the even slot
  localparam int unsigned NR_CLASSES = 2;
  localparam int unsigned NR_MASTERS = 2 * NR_CLASSES;
  localparam int unsigned HP_RD      = 0;
  localparam int unsigned HP_WR      = 1;
  localparam int unsigned LP_RD      = 2;
  localparam int unsigned LP_WR      = 3;

  logic     [NR_MASTERS-1:0][`NR_BANKS-1:0] m_req;
  logic     [NR_MASTERS-1:0][`NR_BANKS-1:0] m_gnt;
  vrow_t    [NR_MASTERS-1:0]                m_row;
  logic     [NR_MASTERS-1:0]                m_wen;
  elen_t    [NR_MASTERS-1:0]                m_wdata;
  strb_t    [NR_MASTERS-1:0]                m_be;
  opqueue_e [NR_MASTERS-1:0]                m_tgt;

  // Set when the write of a class goes first on that bank
  logic [NR_CLASSES-1:0][`NR_BANKS-1:0] prio_q, prio_d;

  assign m_req   = {lp_wr.bank_req, lp_rd.bank_req, hp_wr.bank_req, hp_rd.bank_req};
  assign m_row   = {lp_wr.row, lp_rd.row, hp_wr.row, hp_rd.row};
  assign m_wen   = {lp_wr.wen, lp_rd.wen, hp_wr.wen, hp_rd.wen};
  assign m_wdata = {lp_wr.wdata, lp_rd.wdata, hp_wr.wdata, hp_rd.wdata};
  assign m_be    = {lp_wr.be, lp_rd.be, hp_wr.be, hp_rd.be};
  assign m_tgt   = {lp_wr.tgt, lp_rd.tgt, hp_wr.tgt, hp_rd.tgt};

  //////////////////////////////
  // Per-bank arbitration
  //////////////////////////////

  always_comb begin : p_arbitrate
    int unsigned rd;
    int unsigned wr;
    int unsigned win;
    logic        granted;

    m_gnt       = '0;
    prio_d      = prio_q;
    vrf_req_o   = '0;
    vrf_row_o   = '0;
    vrf_wen_o   = '0;
    vrf_wdata_o = '0;
    vrf_be_o    = '0;
    vrf_tgt_o   = {`NR_BANKS{OPQ_A}};

    for (int b = 0; b < `NR_BANKS; b++) begin
      granted = 1'b0;
      win     = 0;
      // Classes in priority order, the first one asking wins
      for (int c = 0; c < NR_CLASSES; c++) begin
        rd = 2 * c;
        wr = 2 * c + 1;
        if (!granted && (m_req[rd][b] || m_req[wr][b])) begin
          granted = 1'b1;
          if (m_req[rd][b] && m_req[wr][b]) begin
            win          = prio_q[c][b] ? wr : rd;
            prio_d[c][b] = !prio_q[c][b];
          end else begin
            win = m_req[wr][b] ? wr : rd;
          end
          m_gnt[win][b] = 1'b1;
        end
      end

      // Forward the winner, acknowledged in the same cycle
      vrf_req_o[b] = granted;
      if (granted) begin
        vrf_row_o[b]   = m_row[win];
        vrf_wen_o[b]   = m_wen[win];
        vrf_wdata_o[b] = m_wdata[win];
        vrf_be_o[b]    = m_be[win];
        vrf_tgt_o[b]   = m_tgt[win];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= '0;
    end else begin
      prio_q <= prio_d;
    end
  end

  // Each master asks one bank at most, so the OR is its grant
  assign hp_rd.gnt = |m_gnt[HP_RD];
  assign hp_wr.gnt = |m_gnt[HP_WR];
  assign lp_rd.gnt = |m_gnt[LP_RD];
  assign lp_wr.gnt = |m_gnt[LP_WR];

endmodule

/* source/operand_requester.sv */
// VRF access stage for one lane: queue A and the ALU form the high class
// Queue B and the load unit form the low class; exactly two queues are supported
`timescale 1ns/100ps
`include "opreq_defs.svh"

module operand_requester (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Read commands, one per operand queue
  input  logic                [`NR_OPQUEUES-1:0] cmd_valid_i,
  output logic                [`NR_OPQUEUES-1:0] cmd_ready_o,
  input  opreq_pkg::vreg_t    [`NR_OPQUEUES-1:0] cmd_vs_i,
  input  opreq_pkg::vlen_t    [`NR_OPQUEUES-1:0] cmd_vl_i,
  input  opreq_pkg::vew_e     [`NR_OPQUEUES-1:0] cmd_eew_i,
  // Operand queues
  input  logic                [`NR_OPQUEUES-1:0] operand_queue_ready_i,
  output logic                [`NR_OPQUEUES-1:0] operand_issued_o,
  // ALU results
  input  logic                                   alu_result_req_i,
  input  vrf_pkg::vaddr_t                        alu_result_addr_i,
  input  vrf_pkg::elen_t                         alu_result_wdata_i,
  input  vrf_pkg::strb_t                         alu_result_be_i,
  output logic                                   alu_result_gnt_o,
  // Load-unit results
  input  logic                                   ldu_result_req_i,
  input  vrf_pkg::vaddr_t                        ldu_result_addr_i,
  input  vrf_pkg::elen_t                         ldu_result_wdata_i,
  input  vrf_pkg::strb_t                         ldu_result_be_i,
  output logic                                   ldu_result_gnt_o,
  // VRF banks
  output logic                [`NR_BANKS-1:0]    vrf_req_o,
  output vrf_pkg::vrow_t      [`NR_BANKS-1:0]    vrf_row_o,
  output logic                [`NR_BANKS-1:0]    vrf_wen_o,
  output vrf_pkg::elen_t      [`NR_BANKS-1:0]    vrf_wdata_o,
  output vrf_pkg::strb_t      [`NR_BANKS-1:0]    vrf_be_o,
  output opreq_pkg::opqueue_e [`NR_BANKS-1:0]    vrf_tgt_opqueue_o
);

  import vrf_pkg::*;
  import opreq_pkg::*;

  vrf_req_if rd_if [`NR_OPQUEUES] ();
  vrf_req_if alu_if ();
  vrf_req_if ldu_if ();

  bank_sel_t alu_bank;
  logic      ldu_ready;

  //////////////////////////////
  // Operand requesters
  //////////////////////////////

  for (genvar q = 0; q < `NR_OPQUEUES; q++) begin : gen_requesters
    operand_requester_fsm #(
      .QUEUE(opqueue_e'(q))
    ) i_requester (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .cmd_valid_i  (cmd_valid_i[q]),
      .cmd_ready_o  (cmd_ready_o[q]),
      .cmd_vs_i     (cmd_vs_i[q]),
      .cmd_vl_i     (cmd_vl_i[q]),
      .cmd_eew_i    (cmd_eew_i[q]),
      .queue_ready_i(operand_queue_ready_i[q]),
      .issued_o     (operand_issued_o[q]),
      .vrf          (rd_if[q])
    );
  end

  //////////////////////////////
  // Result writers
  //////////////////////////////

  // ALU goes straight to the arbiter
  assign alu_bank         = bank_sel_t'(alu_result_addr_i);
  assign alu_if.bank_req  = alu_result_req_i ? (`NR_BANKS'(1) << alu_bank) : '0;
  assign alu_if.row       = vrow_t'(alu_result_addr_i >> BANK_BITS);
  assign alu_if.wen       = 1'b1;
  assign alu_if.wdata     = alu_result_wdata_i;
  assign alu_if.be        = alu_result_be_i;
  assign alu_if.tgt       = OPQ_A;
  assign alu_result_gnt_o = alu_if.gnt;

  // Load unit is decoupled by one register stage
  assign ldu_result_gnt_o = ldu_result_req_i && ldu_ready;

  result_stream_register i_ldu_register (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(ldu_result_req_i),
    .ready_o(ldu_ready),
    .addr_i (ldu_result_addr_i),
    .wdata_i(ldu_result_wdata_i),
    .be_i   (ldu_result_be_i),
    .vrf    (ldu_if)
  );

  vrf_bank_arbiter i_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .hp_rd      (rd_if[OPQ_A]),
    .hp_wr      (alu_if),
    .lp_rd      (rd_if[OPQ_B]),
    .lp_wr      (ldu_if),
    .vrf_req_o  (vrf_req_o),
    .vrf_row_o  (vrf_row_o),
    .vrf_wen_o  (vrf_wen_o),
    .vrf_wdata_o(vrf_wdata_o),
    .vrf_be_o   (vrf_be_o),
    .vrf_tgt_o  (vrf_tgt_opqueue_o)
  );

endmodule

/* dv/operand_requester_assertions.sv */
// Bound into the bank arbiter of the DUT and expects its four master slots
// Grant columns are checked per bank and fail_cnt is read back by the testbench
`timescale 1ns/100ps
`include "opreq_defs.svh"

module operand_requester_assertions #(
  parameter int unsigned NR_MASTERS = 4
) (
  input logic                                 clk_i,
  input logic                                 rst_ni,
  input logic [`NR_BANKS-1:0]                 vrf_req_i,
  input logic [NR_MASTERS-1:0][`NR_BANKS-1:0] gnt_i
);

  int fail_cnt = 0;

  for (genvar b = 0; b < `NR_BANKS; b++) begin : gen_bank
    logic [NR_MASTERS-1:0] col;

    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_col
      assign col[m] = gnt_i[m][b];
    end

    // At most one master per bank and cycle
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(col))
      else begin
        fail_cnt++;
        $error("bank %0d granted to more than one master", b);
      end
  end

  // Banks stay quiet while reset is held
  a_no_req_in_reset: assert property (
    @(posedge clk_i) (!rst_ni && $past(!rst_ni)) |-> (vrf_req_i == '0))
    else begin
      fail_cnt++;
      $error("bank request seen during reset");
    end

endmodule

bind vrf_bank_arbiter operand_requester_assertions i_assertions (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .vrf_req_i(vrf_req_o),
  .gnt_i    (m_gnt)
);

/* dv/tb_operand_requester.sv */
// Directed testbench; the VRF is only observed, read data is not modeled
// Reads are checked by bank and row, writes also by data and byte enables
`timescale 1ns/100ps
`include "opreq_defs.svh"

module tb_operand_requester;

  import vrf_pkg::*;
  import opreq_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int WAIT_CYCLES = 60;
  // Words moved by the six tests, plus a margin for each
  localparam int TEST_WORDS = 5 + 20 + 15 + 1 + 24 + 17;
  localparam int MARGIN = 40;
  localparam int WATCHDOG_CYCLES = 8 + TEST_WORDS + 6 * MARGIN;

  logic                               clk_i;
  logic                               rst_ni;
  logic     [`NR_OPQUEUES-1:0]        cmd_valid_i;
  logic     [`NR_OPQUEUES-1:0]        cmd_ready_o;
  vreg_t    [`NR_OPQUEUES-1:0]        cmd_vs_i;
  vlen_t    [`NR_OPQUEUES-1:0]        cmd_vl_i;
  vew_e     [`NR_OPQUEUES-1:0]        cmd_eew_i;
  logic     [`NR_OPQUEUES-1:0]        operand_queue_ready_i;
  logic     [`NR_OPQUEUES-1:0]        operand_issued_o;
  logic                               alu_result_req_i;
  vaddr_t                             alu_result_addr_i;
  elen_t                              alu_result_wdata_i;
  strb_t                              alu_result_be_i;
  logic                               alu_result_gnt_o;
  logic                               ldu_result_req_i;
  vaddr_t                             ldu_result_addr_i;
  elen_t                              ldu_result_wdata_i;
  strb_t                              ldu_result_be_i;
  logic                               ldu_result_gnt_o;
  logic     [`NR_BANKS-1:0]           vrf_req_o;
  vrow_t    [`NR_BANKS-1:0]           vrf_row_o;
  logic     [`NR_BANKS-1:0]           vrf_wen_o;
  elen_t    [`NR_BANKS-1:0]           vrf_wdata_o;
  strb_t    [`NR_BANKS-1:0]           vrf_be_o;
  opqueue_e [`NR_BANKS-1:0]           vrf_tgt_opqueue_o;

  // Accesses seen on the banks
  bank_sel_t rd_bank_q[$];
  vrow_t     rd_row_q[$];
  opqueue_e  rd_tgt_q[$];
  bank_sel_t wr_bank_q[$];
  vrow_t     wr_row_q[$];
  elen_t     wr_data_q[$];
  strb_t     wr_be_q[$];

  // Words each requester still owes, and the address it asks for
  int                    model_left[`NR_OPQUEUES];
  int                    model_addr[`NR_OPQUEUES];
  int                    issued_cnt[`NR_OPQUEUES];
  logic [`NR_OPQUEUES-1:0] seen_rd;
  int                    mismatch_cnt;
  int                    fail_cnt;
  int                    assert_cnt;
  logic [31:0]           lfsr_q;

  operand_requester uut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////
  // Bank monitor
  //////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      seen_rd = '0;
      for (int b = 0; b < `NR_BANKS; b++) begin
        if (vrf_req_o[b] && vrf_wen_o[b]) begin
          wr_bank_q.push_back(bank_sel_t'(b));
          wr_row_q.push_back(vrf_row_o[b]);
          wr_data_q.push_back(vrf_wdata_o[b]);
          wr_be_q.push_back(vrf_be_o[b]);
        end else if (vrf_req_o[b]) begin
          rd_bank_q.push_back(bank_sel_t'(b));
          rd_row_q.push_back(vrf_row_o[b]);
          rd_tgt_q.push_back(vrf_tgt_opqueue_o[b]);
          seen_rd[vrf_tgt_opqueue_o[b]] = 1'b1;
        end
      end
      // Both queues on one bank, so the low class must lose
      if (model_left[OPQ_A] > 0 && model_left[OPQ_B] > 0 && &operand_queue_ready_i &&
          (model_addr[OPQ_A] % `NR_BANKS) == (model_addr[OPQ_B] % `NR_BANKS) &&
          seen_rd[OPQ_B]) begin
        fail_cnt++;
        $display("ERROR at %0t: queue B won bank %0d while queue A asked for it",
                 $time, model_addr[OPQ_B] % `NR_BANKS);
      end
      for (int q = 0; q < `NR_OPQUEUES; q++) begin
        if (operand_issued_o[q] !== seen_rd[q]) begin
          fail_cnt++;
          $display("ERROR at %0t: operand_issued_o[%0d] disagrees with the bank reads",
                   $time, q);
        end
        if (operand_issued_o[q]) begin
          issued_cnt[q]++;
        end
        if (seen_rd[q] && model_left[q] > 0) begin
          model_left[q]--;
          model_addr[q]++;
        end
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_row(input string name, input vrow_t got, input vrow_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bank(input string name, input bank_sel_t got, input bank_sel_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input elen_t got, input elen_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_be(input string name, input strb_t got, input strb_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_tgt(input string name, input opqueue_e got, input opqueue_e exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output elen_t w);
    w = '0;
    for (int i = 0; i < `ELEN; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[`ELEN-2:0], lfsr_q[0]};
    end
  endtask

  task automatic clear_lists();
    rd_bank_q.delete();
    rd_row_q.delete();
    rd_tgt_q.delete();
    wr_bank_q.delete();
    wr_row_q.delete();
    wr_data_q.delete();
    wr_be_q.delete();
    for (int q = 0; q < `NR_OPQUEUES; q++) begin
      issued_cnt[q] = 0;
    end
  endtask

  function automatic int count_reads(input opqueue_e q);
    int n;
    n = 0;
    foreach (rd_tgt_q[i]) begin
      if (rd_tgt_q[i] == q) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic logic result_gnt(input logic to_ldu);
    return to_ldu ? ldu_result_gnt_o : alu_result_gnt_o;
  endfunction

  // Every task below starts and ends 10 ns after a rising edge
  task automatic send_cmd(input opqueue_e q, input vreg_t vs, input vlen_t vl,
                          input vew_e eew);
    int cyc;
    int epw;
    cyc = 0;
    epw = 8 >> eew;
    cmd_valid_i[q] = 1'b1;
    cmd_vs_i[q] = vs;
    cmd_vl_i[q] = vl;
    cmd_eew_i[q] = eew;
    @(negedge clk_i);
    while (!cmd_ready_o[q] && cyc < WAIT_CYCLES) begin
      @(negedge clk_i);
      cyc++;
    end
    if (!cmd_ready_o[q]) begin
      fail_cnt++;
      $display("ERROR at %0t: queue %0d never accepted its command", $time, q);
    end
    @(posedge clk_i);
    model_left[q] = (int'(vl) + epw - 1) / epw;
    model_addr[q] = int'(vs) * `VREG_WORDS;
    #10;
    cmd_valid_i[q] = 1'b0;
  endtask

  task automatic write_result(input logic to_ldu, input vaddr_t addr, input elen_t data,
                              input strb_t be, output int waited);
    waited = 0;
    if (to_ldu) begin
      ldu_result_req_i = 1'b1;
      ldu_result_addr_i = addr;
      ldu_result_wdata_i = data;
      ldu_result_be_i = be;
    end else begin
      alu_result_req_i = 1'b1;
      alu_result_addr_i = addr;
      alu_result_wdata_i = data;
      alu_result_be_i = be;
    end
    @(negedge clk_i);
    while (!result_gnt(to_ldu) && waited < WAIT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (!result_gnt(to_ldu)) begin
      fail_cnt++;
      $display("ERROR at %0t: result write to address %0d was never granted", $time, addr);
    end
    @(posedge clk_i);
    #10;
    if (to_ldu) begin
      ldu_result_req_i = 1'b0;
    end else begin
      alu_result_req_i = 1'b0;
    end
  endtask

  task automatic wait_reads(input opqueue_e q, input int n);
    int cyc;
    cyc = 0;
    while (count_reads(q) < n && cyc < WAIT_CYCLES) begin
      @(posedge clk_i);
      #10;
      cyc++;
    end
    if (count_reads(q) < n) begin
      fail_cnt++;
      $display("ERROR at %0t: queue %0d made %0d of %0d reads before giving up",
               $time, q, count_reads(q), n);
    end
  endtask

  task automatic wait_writes(input int n);
    int cyc;
    cyc = 0;
    while (wr_bank_q.size() < n && cyc < WAIT_CYCLES) begin
      @(posedge clk_i);
      #10;
      cyc++;
    end
    if (wr_bank_q.size() < n) begin
      fail_cnt++;
      $display("ERROR at %0t: only %0d of %0d writes reached the banks",
               $time, wr_bank_q.size(), n);
    end
  endtask

  // Reads of one queue must walk the words from base in order
  task automatic check_read_seq(input opqueue_e q, input int base, input int n);
    int k;
    int addr;
    k = 0;
    foreach (rd_tgt_q[i]) begin
      if (rd_tgt_q[i] == q) begin
        addr = base + k;
        check_bank("read bank", rd_bank_q[i], bank_sel_t'(addr % `NR_BANKS));
        check_row("read row", rd_row_q[i], vrow_t'(addr / `NR_BANKS));
        k++;
      end
    end
    check_count("read count", k, n);
  endtask

  task automatic check_write(input int i, input int addr, input elen_t data,
                             input strb_t be);
    if (i < wr_bank_q.size()) begin
      check_bank("write bank", wr_bank_q[i], bank_sel_t'(addr % `NR_BANKS));
      check_row("write row", wr_row_q[i], vrow_t'(addr / `NR_BANKS));
      check_data("write data", wr_data_q[i], data);
      check_be("write be", wr_be_q[i], be);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_single_read();
    clear_lists();
    send_cmd(OPQ_A, 5'd3, 10'd20, EW16);
    wait_reads(OPQ_A, 5);
    check_read_seq(OPQ_A, 48, 5);
    foreach (rd_tgt_q[i]) begin
      check_tgt("read tgt", rd_tgt_q[i], OPQ_A);
    end
    check_count("operand_issued_o[0] pulses", issued_cnt[OPQ_A], 5);
    check_count("writes", wr_bank_q.size(), 0);
  endtask

  task automatic test_zero_length();
    clear_lists();
    send_cmd(OPQ_B, 5'd7, 10'd0, EW8);
    repeat (20) begin
      @(posedge clk_i);
      #10;
    end
    check_count("queue B reads after vl=0", count_reads(OPQ_B), 0);
    check_bit("cmd_ready_o[1] after vl=0", cmd_ready_o[OPQ_B], 1'b1);
  endtask

  task automatic test_queue_not_ready();
    clear_lists();
    operand_queue_ready_i[OPQ_A] = 1'b0;
    send_cmd(OPQ_A, 5'd3, 10'd20, EW16);
    repeat (10) begin
      @(posedge clk_i);
      #10;
    end
    check_count("reads while queue A not ready", rd_tgt_q.size(), 0);
    operand_queue_ready_i[OPQ_A] = 1'b1;
    wait_reads(OPQ_A, 5);
    check_read_seq(OPQ_A, 48, 5);
  endtask

  task automatic test_alu_write();
    elen_t data;
    int    waited;
    clear_lists();
    random_word(data);
    write_result(1'b0, 9'd201, data, 8'ha5, waited);
    check_count("alu_result_gnt_o wait cycles", waited, 0);
    wait_writes(1);
    check_count("alu writes", wr_bank_q.size(), 1);
    check_write(0, 201, data, 8'ha5);
  endtask

  task automatic test_load_contention();
    elen_t data[8];
    int    waited;
    int    stalls;
    stalls = 0;
    clear_lists();
    send_cmd(OPQ_A, 5'd10, 10'd16, EW64);
    // All load writes land on bank 0, which queue A visits every fourth word
    for (int k = 0; k < 8; k++) begin
      random_word(data[k]);
      write_result(1'b1, vaddr_t'(256 + 4 * k), data[k], 8'hff, waited);
      stalls += waited;
    end
    wait_reads(OPQ_A, 16);
    wait_writes(8);
    check_read_seq(OPQ_A, 160, 16);
    check_count("load writes", wr_bank_q.size(), 8);
    for (int k = 0; k < 8; k++) begin
      check_write(k, 256 + 4 * k, data[k], 8'hff);
    end
    check_bit("ldu_result_gnt_o low while entry waits", stalls > 0, 1'b1);
  endtask

  task automatic test_class_arbitration();
    elen_t data;
    int    waited;
    clear_lists();
    random_word(data);
    fork
      send_cmd(OPQ_A, 5'd2, 10'd16, EW32);
      send_cmd(OPQ_B, 5'd6, 10'd32, EW16);
      begin
        repeat (3) begin
          @(posedge clk_i);
          #10;
        end
        write_result(1'b0, 9'd130, data, 8'h0f, waited);
      end
    join
    wait_reads(OPQ_A, 8);
    wait_reads(OPQ_B, 8);
    wait_writes(1);
    check_read_seq(OPQ_A, 32, 8);
    check_read_seq(OPQ_B, 96, 8);
    check_count("alu writes", wr_bank_q.size(), 1);
    check_write(0, 130, data, 8'h0f);
  endtask

  //////////////////////////////
  // Sequence and watchdog
  //////////////////////////////

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    cmd_valid_i = '0;
    cmd_vs_i = '0;
    cmd_vl_i = '0;
    for (int q = 0; q < `NR_OPQUEUES; q++) begin
      cmd_eew_i[q] = EW8;
      model_left[q] = 0;
      model_addr[q] = 0;
    end
    operand_queue_ready_i = '1;
    alu_result_req_i = 1'b0;
    alu_result_addr_i = '0;
    alu_result_wdata_i = '0;
    alu_result_be_i = '0;
    ldu_result_req_i = 1'b0;
    ldu_result_addr_i = '0;
    ldu_result_wdata_i = '0;
    ldu_result_be_i = '0;
    lfsr_q = 32'ha54a_f704;
    mismatch_cnt = 0;
    fail_cnt = 0;
    clear_lists();

    repeat (8) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #10;

    test_single_read();
    test_zero_length();
    test_queue_not_ready();
    test_alu_write();
    test_load_contention();
    test_class_arbitration();

    repeat (2) @(posedge clk_i);
    assert_cnt = uut.i_arbiter.i_assertions.fail_cnt;
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_cnt, fail_cnt, assert_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0 && assert_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_cnt++;
    $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    $display("Something failed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+source
source/vrf_pkg.sv
source/opreq_pkg.sv
source/vrf_req_if.sv
source/operand_requester_fsm.sv
source/result_stream_register.sv
source/vrf_bank_arbiter.sv
source/operand_requester.sv
dv/operand_requester_assertions.sv
dv/tb_operand_requester.sv
